// File: sim.f
+incdir+common
common/mul_pkg.sv
datapath/radix4_step.sv
datapath/mul_datapath.sv
hw/mul_control.sv
hw/result_stage.sv
hw/radix4_multiplier.sv
bench/mul_assertions.sv
bench/tb_radix4_multiplier.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the radix-4 multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_radix4_multiplier \
    -o tb_radix4_multiplier

./obj_dir/tb_radix4_multiplier > "$LOG" 2>&1

cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// File: bench/tb_radix4_multiplier.sv
// Radix-4 multiplier testbench

`default_nettype none
`timescale 1ns/10ps

`include "mul_settings.svh"

module tb_radix4_multiplier;

    localparam int NUM_OPS      = 400;
    localparam int NUM_DIRECTED = 9;
    localparam int LATENCY      = 9;
    localparam int DONE_WAIT    = 12;
    localparam int MAX_CYCLES   = NUM_OPS * 12 + 50;
    localparam int W            = `MUL_WIDTH;
    localparam int FRAC         = `MUL_FRAC_BITS;

    logic              ctl_clk;
    logic              reset;
    logic              trigger;
    mul_pkg::operand_t a;
    mul_pkg::operand_t b;
    logic              ready;
    logic              done;
    mul_pkg::operand_t y;
    logic              overflow;

    integer            seed;
    int                value_errors;
    int                protocol_errors;
    int                cycles;
    mul_pkg::operand_t last_y;
    logic              last_ovf;

    radix4_multiplier u_radix4_multiplier (
        .ctl_clk  (ctl_clk),
        .reset    (reset),
        .trigger  (trigger),
        .a        (a),
        .b        (b),
        .ready    (ready),
        .done     (done),
        .y        (y),
        .overflow (overflow)
    );

    initial begin
        ctl_clk = 1'b0;
    end

    always #50 ctl_clk = ~ctl_clk;

    function automatic mul_pkg::product_t model_product(input mul_pkg::operand_t x,
                                                        input mul_pkg::operand_t z);
        mul_pkg::product_t wide_x;
        mul_pkg::product_t wide_z;
        wide_x = mul_pkg::product_t'(x);
        wide_z = mul_pkg::product_t'(z);
        return wide_x * wide_z;
    endfunction

    task automatic check_result(input string name, input mul_pkg::operand_t expected,
                                input mul_pkg::operand_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // Cycles without a trigger, result must hold
    task automatic idle_cycles(input string name, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge ctl_clk);
            #1;
            if (done) begin
                $display("%s: unexpected extra done pulse", name);
                protocol_errors++;
            end
            check_flag({name, " idle ready"}, 1'b1, ready);
            check_result({name, " idle y"}, last_y, y);
            check_flag({name, " idle overflow"}, last_ovf, overflow);
        end
    endtask

    // Starts one operation and waits for its done pulse
    task automatic run_op(input string name, input mul_pkg::operand_t op_a,
                          input mul_pkg::operand_t op_b, input bit late_trigger);
        mul_pkg::product_t p;
        mul_pkg::operand_t exp_y;
        logic              exp_ovf;
        int                cyc;
        bit                seen;
        p       = model_product(op_a, op_b);
        exp_y   = p[FRAC+W-1:FRAC];
        exp_ovf = |p[2*W-1:FRAC+W];
        cyc     = 0;
        seen    = 1'b0;
        if (!ready) begin
            $display("%s: ready was low when the operation started", name);
            protocol_errors++;
        end
        a       = op_a;
        b       = op_b;
        trigger = 1'b1;
        while (!seen && cyc < DONE_WAIT) begin
            @(posedge ctl_clk);
            #1;
            cyc++;
            if (cyc == 1) begin
                // Operands may change once accepted
                trigger = 1'b0;
                a       = $random(seed);
                b       = $random(seed);
            end
            if (late_trigger && cyc == 3) begin
                a       = ~op_a;
                b       = op_b + 32'd1;
                trigger = 1'b1;
            end
            if (late_trigger && cyc == 4) begin
                trigger = 1'b0;
            end
            if (done) begin
                seen = 1'b1;
            end else begin
                check_flag({name, " busy ready"}, 1'b0, ready);
                check_result({name, " held y"}, last_y, y);
                check_flag({name, " held overflow"}, last_ovf, overflow);
            end
        end
        trigger = 1'b0;
        if (!seen) begin
            $display("%s: done pulse missing", name);
            protocol_errors++;
        end else begin
            // First counted edge is the accepting one
            if (cyc - 1 != LATENCY) begin
                $display("%s: done came %0d cycles after the accepting edge instead of %0d",
                         name, cyc - 1, LATENCY);
                protocol_errors++;
            end
            check_result(name, exp_y, y);
            check_flag({name, " overflow"}, exp_ovf, overflow);
            check_flag({name, " done ready"}, 1'b1, ready);
        end
        last_y   = exp_y;
        last_ovf = exp_ovf;
    endtask

    always @(posedge ctl_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            protocol_errors++;
            finish_run();
        end
    end

    initial begin
        mul_pkg::operand_t ra;
        mul_pkg::operand_t rb;
        seed            = 32'h0abf_ceba;
        value_errors    = 0;
        protocol_errors = 0;
        cycles          = 0;
        last_y          = '0;
        last_ovf        = 1'b0;
        reset           = 1'b0;
        trigger         = 1'b0;
        a               = '0;
        b               = '0;

        repeat (2) @(posedge ctl_clk);
        #1;
        check_flag("reset ready", 1'b0, ready);
        check_flag("reset done", 1'b0, done);
        check_flag("reset overflow", 1'b0, overflow);
        check_result("reset y", '0, y);
        reset = 1'b1;
        @(posedge ctl_clk);
        #1;
        check_flag("ready after reset", 1'b1, ready);

        // Corner operands
        run_op("zero_a", '0, $random(seed), 1'b0);
        run_op("zero_b", $random(seed), '0, 1'b0);
        run_op("one_fixed", mul_pkg::operand_t'(1) << FRAC, $random(seed), 1'b0);
        run_op("all_ones", '1, '1, 1'b0);
        idle_cycles("corners", 2);

        run_op("overflow_set", 32'hffff_ffff, 32'h0000_0200, 1'b0);
        run_op("overflow_clear", 32'd3 << FRAC, 32'd5 << FRAC, 1'b0);
        idle_cycles("overflow", 1);

        run_op("ignored_trigger", $random(seed), $random(seed), 1'b1);
        idle_cycles("ignored_trigger", 3);

        // Second trigger lands in the done cycle
        run_op("b2b_first", $random(seed), $random(seed), 1'b0);
        run_op("b2b_second", $random(seed), $random(seed), 1'b0);

        for (int i = 0; i < NUM_OPS - NUM_DIRECTED; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            if (($random(seed) & 3) == 0) begin
                ra = ra & 32'h0000_ffff;
                rb = rb & 32'h0000_ffff;
            end
            run_op("random", ra, rb, 1'b0);
            if (i % 8 == 7) begin
                idle_cycles("random", 2);
            end
        end

        idle_cycles("final", 2);
        finish_run();
    end

endmodule

`default_nettype wire

// File: bench/mul_assertions.sv
// Multiplier protocol assertions

`default_nettype none
`timescale 1ns/10ps

module mul_assertions (
    input logic ctl_clk,
    input logic reset,
    input logic load,
    input logic finish,
    input logic ready,
    input logic done
);

    logic busy;

    // Calculation in flight, from the cycle after load up to finish
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (finish) begin
            busy <= 1'b0;
        end
    end

    done_one_cycle: assert property (@(posedge ctl_clk) disable iff (!reset)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    finish_not_load: assert property (@(posedge ctl_clk) disable iff (!reset)
        !(finish && load))
        else $error("finish and load high in the same cycle");

    ready_low_busy: assert property (@(posedge ctl_clk) disable iff (!reset)
        busy |-> !ready)
        else $error("ready high while a calculation is in flight");

endmodule

bind mul_control mul_assertions u_control_assertions (
    .ctl_clk (ctl_clk),
    .reset   (reset),
    .load    (load),
    .finish  (finish),
    .ready   (ready),
    .done    (1'b0)
);

bind result_stage mul_assertions u_result_assertions (
    .ctl_clk (ctl_clk),
    .reset   (reset),
    .load    (1'b0),
    .finish  (finish),
    .ready   (1'b0),
    .done    (done)
);

`default_nettype wire

// File: hw/radix4_multiplier.sv
// Radix-4 fixed-point multiplier

`default_nettype none
`timescale 1ns/10ps

module radix4_multiplier (
    input  logic              ctl_clk,
    input  logic              reset,
    input  logic              trigger,
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    output logic              ready,
    output logic              done,
    output mul_pkg::operand_t y,
    output logic              overflow
);

    logic              load;
    logic              step;
    logic              finish;
    mul_pkg::product_t product;

    mul_control u_mul_control (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .load    (load),
        .step    (step),
        .finish  (finish)
    );

    mul_datapath u_mul_datapath (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .load    (load),
        .step    (step),
        .a       (a),
        .b       (b),
        .product (product)
    );

    // Product is exact once finish rises
    result_stage u_result_stage (
        .ctl_clk  (ctl_clk),
        .reset    (reset),
        .finish   (finish),
        .product  (product),
        .y        (y),
        .overflow (overflow),
        .done     (done)
    );

endmodule

`default_nettype wire

// File: hw/result_stage.sv
// Fixed-point result stage

`default_nettype none
`timescale 1ns/10ps

`include "mul_settings.svh"

module result_stage (
    input  logic              ctl_clk,
    input  logic              reset,
    input  logic              finish,
    input  mul_pkg::product_t product,
    output mul_pkg::operand_t y,
    output logic              overflow,
    output logic              done
);

    localparam int W    = `MUL_WIDTH;
    localparam int FRAC = `MUL_FRAC_BITS;

    mul_pkg::operand_t slice;
    logic              above;

    // Drop the low fraction bits of the product
    assign slice = product[FRAC+W-1:FRAC];
    assign above = |product[2*W-1:FRAC+W];

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            y        <= '0;
            overflow <= 1'b0;
            done     <= 1'b0;
        end else if (finish) begin
            y        <= slice;
            overflow <= above;
            done     <= 1'b1;
        end else begin
            // Result holds until the next finish
            done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/mul_control.sv
// Multiplier control

`default_nettype none
`timescale 1ns/10ps

`include "mul_settings.svh"

module mul_control (
    input  logic ctl_clk,
    input  logic reset,
    input  logic trigger,
    output logic ready,
    output logic load,
    output logic step,
    output logic finish
);

    localparam mul_pkg::step_count_t LAST_STEP = mul_pkg::step_count_t'(`MUL_STEPS);

    mul_pkg::mul_state_t  state;
    mul_pkg::mul_state_t  state_next;
    mul_pkg::step_count_t count;
    logic                 calc;

    assign calc   = (state == mul_pkg::MUL_CALC);
    // The only accept decision in the design
    assign load   = ready && trigger;
    assign step   = calc && (count < LAST_STEP);
    assign finish = calc && (count == LAST_STEP);

    always_comb begin
        case (state)
            mul_pkg::MUL_IDLE: begin
                state_next = load ? mul_pkg::MUL_CALC : mul_pkg::MUL_IDLE;
            end
            mul_pkg::MUL_CALC: begin
                state_next = finish ? mul_pkg::MUL_DONE : mul_pkg::MUL_CALC;
            end
            mul_pkg::MUL_DONE: begin
                // Back-to-back start
                state_next = load ? mul_pkg::MUL_CALC : mul_pkg::MUL_IDLE;
            end
            default: begin
                state_next = mul_pkg::MUL_IDLE;
            end
        endcase
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= mul_pkg::MUL_IDLE;
            count <= '0;
            ready <= 1'b0;
        end else begin
            state <= state_next;
            // Ready follows the state being entered
            ready <= (state_next != mul_pkg::MUL_CALC);
            if (load) begin
                count <= '0;
            end else if (step) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: datapath/mul_datapath.sv
// Multiplier datapath

`default_nettype none
`timescale 1ns/10ps

`include "mul_settings.svh"

module mul_datapath (
    input  logic              ctl_clk,
    input  logic              reset,
    input  logic              load,
    input  logic              step,
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    output mul_pkg::product_t product
);

    localparam int W     = `MUL_WIDTH;
    localparam int SHIFT = 2 * `MUL_DIGITS_PER_STEP;

    mul_pkg::operand_t    multiplicand;
    mul_pkg::product_t    acc;
    logic [W+SHIFT-1:0]   step_sum;

    // Low half starts as the multiplier and drains four bits per step
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            multiplicand <= '0;
            acc          <= '0;
        end else if (load) begin
            multiplicand <= a;
            acc          <= {{W{1'b0}}, b};
        end else if (step) begin
            acc <= {step_sum, acc[W-1:SHIFT]};
        end
    end

    radix4_step u_radix4_step (
        .multiplicand (multiplicand),
        .acc_high     (acc[2*W-1:W]),
        .digits       (acc[SHIFT-1:0]),
        .sum          (step_sum)
    );

    assign product = acc;

endmodule

`default_nettype wire

// File: datapath/radix4_step.sv
// Radix-4 step adder

`default_nettype none
`timescale 1ns/10ps

`include "mul_settings.svh"

module radix4_step (
    input  mul_pkg::operand_t                                  multiplicand,
    input  mul_pkg::operand_t                                  acc_high,
    input  logic [2*`MUL_DIGITS_PER_STEP-1:0]                  digits,
    output logic [`MUL_WIDTH+2*`MUL_DIGITS_PER_STEP-1:0]       sum
);

    localparam int W  = `MUL_WIDTH;
    localparam int D  = `MUL_DIGITS_PER_STEP;
    localparam int SW = W + 2 * D;

    logic [W+1:0] mul_x1;
    logic [W+1:0] mul_x2;
    logic [W+1:0] mul_x3;

    // Multiples shared by all digits
    assign mul_x1 = {2'b00, multiplicand};
    assign mul_x2 = {1'b0, multiplicand, 1'b0};
    assign mul_x3 = mul_x1 + mul_x2;

    for (genvar i = 0; i < D; i++) begin : g_digit
        logic [W+1:0]  pick;
        logic [SW-1:0] partial;

        always_comb begin
            case (digits[2*i+1:2*i])
                2'd0:    pick = '0;
                2'd1:    pick = mul_x1;
                2'd2:    pick = mul_x2;
                default: pick = mul_x3;
            endcase
        end

        // Higher digits weigh four times more
        if (i == 0) begin : g_first
            assign partial = SW'(pick);
        end else begin : g_next
            assign partial = g_digit[i-1].partial + (SW'(pick) << (2 * i));
        end
    end

    // New top of the accumulator, cannot exceed SW bits
    assign sum = g_digit[D-1].partial + SW'(acc_high);

endmodule

`default_nettype wire

// File: common/mul_pkg.sv
// Multiplier types

`default_nettype none

`include "mul_settings.svh"

package mul_pkg;

    // Operand or fixed-point result word
    typedef logic [`MUL_WIDTH-1:0] operand_t;

    // Full unsigned product
    typedef logic [2*`MUL_WIDTH-1:0] product_t;

    // Controller states
    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_CALC = 2'd1,
        MUL_DONE = 2'd2
    } mul_state_t;

    // Holds 0 up to MUL_STEPS
    typedef logic [3:0] step_count_t;

endpackage

`default_nettype wire

// File: common/mul_settings.svh
// Multiplier settings

`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// Operand and result width
`define MUL_WIDTH 32

// Fraction bits of the fixed-point format
`define MUL_FRAC_BITS 8

// Radix-4 digits per cycle, two bits each
`define MUL_DIGITS_PER_STEP 2

// Cycles per multiplication
`define MUL_STEPS (`MUL_WIDTH / (2 * `MUL_DIGITS_PER_STEP))

`endif
